/* hw/mipsPkg.sv */
package mipsPkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int opWidth      = 6;
    localparam int functWidth   = 6;
    localparam int immWidth     = 16;
    localparam int aluOpWidth   = 4;
    localparam int brTypeWidth  = 3;

    //////////////////////////////
    // Primary opcodes
    //////////////////////////////
    localparam logic [opWidth-1:0] opRtype  = 6'b000000;
    localparam logic [opWidth-1:0] opRegimm = 6'b000001;
    localparam logic [opWidth-1:0] opBeq    = 6'b000100;
    localparam logic [opWidth-1:0] opBne    = 6'b000101;
    localparam logic [opWidth-1:0] opBlez   = 6'b000110;
    localparam logic [opWidth-1:0] opBgtz   = 6'b000111;
    localparam logic [opWidth-1:0] opAddi   = 6'b001000;
    localparam logic [opWidth-1:0] opAddiu  = 6'b001001;
    localparam logic [opWidth-1:0] opSlti   = 6'b001010;
    localparam logic [opWidth-1:0] opSltiu  = 6'b001011;
    localparam logic [opWidth-1:0] opAndi   = 6'b001100;
    localparam logic [opWidth-1:0] opOri    = 6'b001101;
    localparam logic [opWidth-1:0] opXori   = 6'b001110;
    localparam logic [opWidth-1:0] opLui    = 6'b001111;

    // R-type function codes
    localparam logic [functWidth-1:0] functSll  = 6'b000000;
    localparam logic [functWidth-1:0] functSrl  = 6'b000010;
    localparam logic [functWidth-1:0] functSra  = 6'b000011;
    localparam logic [functWidth-1:0] functSllv = 6'b000100;
    localparam logic [functWidth-1:0] functSrlv = 6'b000110;
    localparam logic [functWidth-1:0] functSrav = 6'b000111;
    localparam logic [functWidth-1:0] functAdd  = 6'b100000;
    localparam logic [functWidth-1:0] functAddu = 6'b100001;
    localparam logic [functWidth-1:0] functSub  = 6'b100010;
    localparam logic [functWidth-1:0] functSubu = 6'b100011;
    localparam logic [functWidth-1:0] functAnd  = 6'b100100;
    localparam logic [functWidth-1:0] functOr   = 6'b100101;
    localparam logic [functWidth-1:0] functXor  = 6'b100110;
    localparam logic [functWidth-1:0] functNor  = 6'b100111;
    localparam logic [functWidth-1:0] functSlt  = 6'b101010;
    localparam logic [functWidth-1:0] functSltu = 6'b101011;

    // Regimm selectors, carried in the rt field
    localparam logic [regAddrWidth-1:0] rtBltz = 5'b00000;
    localparam logic [regAddrWidth-1:0] rtBgez = 5'b00001;

    //////////////////////////////
    // ALU operations
    //////////////////////////////
    localparam logic [aluOpWidth-1:0] aluAnd  = 4'b0000;
    localparam logic [aluOpWidth-1:0] aluOr   = 4'b0001;
    localparam logic [aluOpWidth-1:0] aluAdd  = 4'b0010;
    localparam logic [aluOpWidth-1:0] aluXor  = 4'b0011;
    localparam logic [aluOpWidth-1:0] aluNor  = 4'b0100;
    localparam logic [aluOpWidth-1:0] aluSlt  = 4'b0101;
    localparam logic [aluOpWidth-1:0] aluSub  = 4'b0110;
    localparam logic [aluOpWidth-1:0] aluSltu = 4'b0111;
    localparam logic [aluOpWidth-1:0] aluLui  = 4'b1000;
    localparam logic [aluOpWidth-1:0] aluSll  = 4'b1001;
    localparam logic [aluOpWidth-1:0] aluSrl  = 4'b1010;
    localparam logic [aluOpWidth-1:0] aluSra  = 4'b1011;

    // Branch comparisons
    localparam logic [brTypeWidth-1:0] brNone = 3'd0;
    localparam logic [brTypeWidth-1:0] brEq   = 3'd1;
    localparam logic [brTypeWidth-1:0] brNe   = 3'd2;
    localparam logic [brTypeWidth-1:0] brLez  = 3'd3;
    localparam logic [brTypeWidth-1:0] brGtz  = 3'd4;
    localparam logic [brTypeWidth-1:0] brLtz  = 3'd5;
    localparam logic [brTypeWidth-1:0] brGez  = 3'd6;

    // Same word, R and I field layouts
    typedef union packed {
        struct packed {
            logic [opWidth-1:0]      opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [regAddrWidth-1:0] rd;
            logic [regAddrWidth-1:0] shamt;
            logic [functWidth-1:0]   funct;
        } r;
        struct packed {
            logic [opWidth-1:0]      opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [immWidth-1:0]     imm;
        } i;
    } instrWord;

endpackage

/* hw/stageIf.sv */
`timescale 1ns/1ps

// Decoded instruction, decode to execute
interface decodeIf;
    logic                               valid;
    logic                               ready;
    logic [mipsPkg::aluOpWidth-1:0]     aluOp;
    logic [mipsPkg::dataWidth-1:0]      operandA;
    logic [mipsPkg::dataWidth-1:0]      operandB;
    logic [mipsPkg::dataWidth-1:0]      rtValue;
    logic [mipsPkg::brTypeWidth-1:0]    branchType;
    logic [mipsPkg::regAddrWidth-1:0]   dest;
    logic                               writeEn;
    logic                               illegal;

    modport src (output valid, aluOp, operandA, operandB, rtValue, branchType,
                 output dest, writeEn, illegal, input ready);
    modport dst (input valid, aluOp, operandA, operandB, rtValue, branchType,
                 input dest, writeEn, illegal, output ready);
endinterface

// Execute outcome, execute to result
interface execIf;
    logic                               valid;
    logic                               ready;
    logic [mipsPkg::dataWidth-1:0]      data;
    logic [mipsPkg::regAddrWidth-1:0]   dest;
    logic                               writeEn;
    logic                               branchTaken;
    logic                               illegal;

    modport src (output valid, data, dest, writeEn, branchTaken, illegal,
                 input ready);
    modport dst (input valid, data, dest, writeEn, branchTaken, illegal,
                 output ready);
endinterface

/* hw/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            inValid,
    output logic                            inReady,
    input  mipsPkg::instrWord               instr,
    input  logic [mipsPkg::dataWidth-1:0]   rsValue,
    input  logic [mipsPkg::dataWidth-1:0]   rtValue,
    decodeIf.src                            down
);

    logic [mipsPkg::aluOpWidth-1:0]     aluOp;
    logic [mipsPkg::brTypeWidth-1:0]    branchType;
    logic [mipsPkg::regAddrWidth-1:0]   dest;
    logic                               writeEn;
    logic                               illegal;
    logic                               zeroExt;
    logic                               useImm;
    logic                               useShamt;
    logic [mipsPkg::dataWidth-1:0]      immExt;
    logic [mipsPkg::dataWidth-1:0]      operandA;
    logic [mipsPkg::dataWidth-1:0]      operandB;

    //////////////////////////////
    // Control decode
    //////////////////////////////
    always_comb begin
        aluOp      = mipsPkg::aluAdd;
        branchType = mipsPkg::brNone;
        dest       = '0;
        writeEn    = 1'b0;
        illegal    = 1'b0;
        zeroExt    = 1'b0;
        useImm     = 1'b0;
        useShamt   = 1'b0;

        if (instr.i.opcode == mipsPkg::opRtype) begin
            dest    = instr.r.rd;
            writeEn = 1'b1;
            case (instr.r.funct)
                mipsPkg::functAdd, mipsPkg::functAddu: aluOp = mipsPkg::aluAdd;
                mipsPkg::functSub, mipsPkg::functSubu: aluOp = mipsPkg::aluSub;
                mipsPkg::functAnd:  aluOp = mipsPkg::aluAnd;
                mipsPkg::functOr:   aluOp = mipsPkg::aluOr;
                mipsPkg::functXor:  aluOp = mipsPkg::aluXor;
                mipsPkg::functNor:  aluOp = mipsPkg::aluNor;
                mipsPkg::functSlt:  aluOp = mipsPkg::aluSlt;
                mipsPkg::functSltu: aluOp = mipsPkg::aluSltu;
                mipsPkg::functSll: begin
                    aluOp    = mipsPkg::aluSll;
                    useShamt = 1'b1;
                end
                mipsPkg::functSrl: begin
                    aluOp    = mipsPkg::aluSrl;
                    useShamt = 1'b1;
                end
                mipsPkg::functSra: begin
                    aluOp    = mipsPkg::aluSra;
                    useShamt = 1'b1;
                end
                mipsPkg::functSllv: aluOp = mipsPkg::aluSll;
                mipsPkg::functSrlv: aluOp = mipsPkg::aluSrl;
                mipsPkg::functSrav: aluOp = mipsPkg::aluSra;
                default:            illegal = 1'b1;
            endcase
        end else begin
            dest    = instr.i.rt;
            writeEn = 1'b1;
            useImm  = 1'b1;
            case (instr.i.opcode)
                mipsPkg::opAddi, mipsPkg::opAddiu: aluOp = mipsPkg::aluAdd;
                mipsPkg::opSlti:  aluOp = mipsPkg::aluSlt;
                mipsPkg::opSltiu: aluOp = mipsPkg::aluSltu;
                mipsPkg::opLui:   aluOp = mipsPkg::aluLui;
                mipsPkg::opAndi: begin
                    aluOp   = mipsPkg::aluAnd;
                    zeroExt = 1'b1;
                end
                mipsPkg::opOri: begin
                    aluOp   = mipsPkg::aluOr;
                    zeroExt = 1'b1;
                end
                mipsPkg::opXori: begin
                    aluOp   = mipsPkg::aluXor;
                    zeroExt = 1'b1;
                end
                mipsPkg::opBeq:  branchType = mipsPkg::brEq;
                mipsPkg::opBne:  branchType = mipsPkg::brNe;
                mipsPkg::opBlez: branchType = mipsPkg::brLez;
                mipsPkg::opBgtz: branchType = mipsPkg::brGtz;
                mipsPkg::opRegimm: begin
                    if (instr.i.rt == mipsPkg::rtBltz) begin
                        branchType = mipsPkg::brLtz;
                    end else if (instr.i.rt == mipsPkg::rtBgez) begin
                        branchType = mipsPkg::brGez;
                    end else begin
                        illegal = 1'b1;
                    end
                end
                default: illegal = 1'b1;
            endcase
        end

        // Branches and rejected words write nothing
        if (illegal || branchType != mipsPkg::brNone) begin
            writeEn = 1'b0;
            dest    = '0;
        end
    end

    // Operand selection
    assign immExt = zeroExt ? {{(mipsPkg::dataWidth-mipsPkg::immWidth){1'b0}}, instr.i.imm}
                            : {{(mipsPkg::dataWidth-mipsPkg::immWidth){instr.i.imm[15]}},
                               instr.i.imm};
    assign operandA = useShamt
        ? {{(mipsPkg::dataWidth-mipsPkg::regAddrWidth){1'b0}}, instr.r.shamt}
        : rsValue;
    assign operandB = useImm ? immExt : rtValue;

    //////////////////////////////
    // Stage register
    //////////////////////////////
    assign inReady = !down.valid || down.ready;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            down.valid <= 1'b0;
        end else if (inReady) begin
            down.valid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            down.aluOp      <= aluOp;
            down.operandA   <= operandA;
            down.operandB   <= operandB;
            down.rtValue    <= rtValue;
            down.branchType <= branchType;
            down.dest       <= dest;
            down.writeEn    <= writeEn;
            down.illegal    <= illegal;
        end
    end

endmodule

/* hw/aluExecute.sv */
`timescale 1ns/1ps

module aluExecute (
    input  logic    clk,
    input  logic    rstN,
    decodeIf.dst    up,
    execIf.src      down
);

    logic [mipsPkg::dataWidth-1:0]      aluResult;
    logic [mipsPkg::regAddrWidth-1:0]   shiftAmt;
    logic                               taken;
    logic                               rsZero;
    logic                               rsNeg;

    //////////////////////////////
    // ALU and shifter
    //////////////////////////////
    assign shiftAmt = up.operandA[mipsPkg::regAddrWidth-1:0];

    always_comb begin
        aluResult = '0;
        case (up.aluOp)
            mipsPkg::aluAnd:  aluResult = up.operandA & up.operandB;
            mipsPkg::aluOr:   aluResult = up.operandA | up.operandB;
            mipsPkg::aluXor:  aluResult = up.operandA ^ up.operandB;
            mipsPkg::aluNor:  aluResult = ~(up.operandA | up.operandB);
            mipsPkg::aluAdd:  aluResult = up.operandA + up.operandB;
            mipsPkg::aluSub:  aluResult = up.operandA - up.operandB;
            mipsPkg::aluSlt:  aluResult[0] = $signed(up.operandA) < $signed(up.operandB);
            mipsPkg::aluSltu: aluResult[0] = up.operandA < up.operandB;
            mipsPkg::aluLui:  aluResult = {up.operandB[mipsPkg::immWidth-1:0],
                                           {mipsPkg::immWidth{1'b0}}};
            mipsPkg::aluSll:  aluResult = up.operandB << shiftAmt;
            mipsPkg::aluSrl:  aluResult = up.operandB >> shiftAmt;
            mipsPkg::aluSra:  aluResult = $signed(up.operandB) >>> shiftAmt;
            default:          aluResult = '0;
        endcase
    end

    // Branch comparator, rs value sits in operandA
    assign rsZero = (up.operandA == '0);
    assign rsNeg  = up.operandA[mipsPkg::dataWidth-1];

    always_comb begin
        case (up.branchType)
            mipsPkg::brEq:  taken = (up.operandA == up.rtValue);
            mipsPkg::brNe:  taken = (up.operandA != up.rtValue);
            mipsPkg::brLez: taken = rsNeg || rsZero;
            mipsPkg::brGtz: taken = !rsNeg && !rsZero;
            mipsPkg::brLtz: taken = rsNeg;
            mipsPkg::brGez: taken = !rsNeg;
            default:        taken = 1'b0;
        endcase
    end

    //////////////////////////////
    // Stage register
    //////////////////////////////
    assign up.ready = !down.valid || down.ready;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            down.valid <= 1'b0;
        end else if (up.ready) begin
            down.valid <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up.valid && up.ready) begin
            down.data        <= (up.branchType != mipsPkg::brNone) ? '0 : aluResult;
            down.dest        <= up.dest;
            down.writeEn     <= up.writeEn;
            down.branchTaken <= taken;
            down.illegal     <= up.illegal;
        end
    end

endmodule

/* hw/resultStage.sv */
`timescale 1ns/1ps

module resultStage (
    input  logic                                clk,
    input  logic                                rstN,
    execIf.dst                                  up,
    output logic                                outValid,
    input  logic                                outReady,
    output logic [mipsPkg::dataWidth-1:0]       outData,
    output logic [mipsPkg::regAddrWidth-1:0]    outDest,
    output logic                                outWriteEn,
    output logic                                outBranchTaken,
    output logic                                outIllegal
);

    logic load;

    assign up.ready = !outValid || outReady;
    assign load     = up.valid && up.ready;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (up.ready) begin
            outValid <= up.valid;
        end
    end

    //////////////////////////////
    // Output register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (load) begin
            outData        <= up.illegal ? '0 : up.data;
            outDest        <= up.dest;
            // r0 is hardwired, never written
            outWriteEn     <= up.writeEn && (up.dest != '0) && !up.illegal;
            outBranchTaken <= up.branchTaken;
            outIllegal     <= up.illegal;
        end
    end

endmodule

/* hw/mipsExecUnit.sv */
`timescale 1ns/1ps

module mipsExecUnit (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                inValid,
    output logic                                inReady,
    input  mipsPkg::instrWord                   instr,
    input  logic [mipsPkg::dataWidth-1:0]       rsValue,
    input  logic [mipsPkg::dataWidth-1:0]       rtValue,
    output logic                                outValid,
    input  logic                                outReady,
    output logic [mipsPkg::dataWidth-1:0]       outData,
    output logic [mipsPkg::regAddrWidth-1:0]    outDest,
    output logic                                outWriteEn,
    output logic                                outBranchTaken,
    output logic                                outIllegal
);

    decodeIf decodeBus ();
    execIf   execBus ();

    // Decode, execute, result
    instrDecode uDecode (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (inValid),
        .inReady (inReady),
        .instr   (instr),
        .rsValue (rsValue),
        .rtValue (rtValue),
        .down    (decodeBus.src)
    );

    aluExecute uExecute (
        .clk  (clk),
        .rstN (rstN),
        .up   (decodeBus.dst),
        .down (execBus.src)
    );

    resultStage uResult (
        .clk            (clk),
        .rstN           (rstN),
        .up             (execBus.dst),
        .outValid       (outValid),
        .outReady       (outReady),
        .outData        (outData),
        .outDest        (outDest),
        .outWriteEn     (outWriteEn),
        .outBranchTaken (outBranchTaken),
        .outIllegal     (outIllegal)
    );

endmodule

/* tb/mipsExecUnit_properties.sv */
`timescale 1ns/1ps

module mipsExecUnit_properties (
    input logic                             clk,
    input logic                             rstN,
    input logic                             outValid,
    input logic                             outReady,
    input logic [mipsPkg::dataWidth-1:0]    outData,
    input logic [mipsPkg::regAddrWidth-1:0] outDest,
    input logic                             outWriteEn,
    input logic                             outBranchTaken,
    input logic                             outIllegal
);

    // Nothing leaves the unit while reset is held
    resetIdle: assert property (@(posedge clk) !rstN |-> !outValid)
        else $error("outValid high while reset is asserted");

    // A stalled result keeps every output field
    holdStable: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(outData) && $stable(outDest)
            && $stable(outWriteEn) && $stable(outBranchTaken) && $stable(outIllegal))
        else $error("Output changed or dropped while stalled");

    noBadWrite: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> !(outWriteEn && (outDest == '0 || outIllegal)))
        else $error("Write enable set for r0 or for an illegal instruction");

endmodule

bind mipsExecUnit mipsExecUnit_properties uProps (
    .clk            (clk),
    .rstN           (rstN),
    .outValid       (outValid),
    .outReady       (outReady),
    .outData        (outData),
    .outDest        (outDest),
    .outWriteEn     (outWriteEn),
    .outBranchTaken (outBranchTaken),
    .outIllegal     (outIllegal)
);

/* tb/mipsExecUnit_tb.sv */
`timescale 1ns/1ps

module mipsExecUnit_tb;

    localparam int clkPeriod    = 4;
    localparam int resetCycles  = 8;
    localparam int cyclesPerRow = 20;
    localparam int drainCycles  = 4;

    // flags is {writeEn, branchTaken, illegal}
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] data;
        logic [4:0]  dest;
        logic [2:0]  flags;
    } testRow;

    logic              clk;
    logic              rstN;
    logic              inValid;
    logic              inReady;
    mipsPkg::instrWord instr;
    logic [31:0]       rsValue;
    logic [31:0]       rtValue;
    logic              outValid;
    logic              outReady;
    logic [31:0]       outData;
    logic [4:0]        outDest;
    logic              outWriteEn;
    logic              outBranchTaken;
    logic              outIllegal;

    testRow     rows[$];
    testRow     expQ[$];
    int         matched;
    logic [7:0] lfsr;

    mipsExecUnit DUT (
        .clk            (clk),
        .rstN           (rstN),
        .inValid        (inValid),
        .inReady        (inReady),
        .instr          (instr),
        .rsValue        (rsValue),
        .rtValue        (rtValue),
        .outValid       (outValid),
        .outReady       (outReady),
        .outData        (outData),
        .outDest        (outDest),
        .outWriteEn     (outWriteEn),
        .outBranchTaken (outBranchTaken),
        .outIllegal     (outIllegal)
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    //////////////////////////////
    // Encoding and stimulus helpers
    //////////////////////////////
    function automatic logic [31:0] rInst(input logic [5:0] funct, input logic [4:0] rd,
                                          input logic [4:0] shamt);
        return {mipsPkg::opRtype, 5'd1, 5'd2, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] iInst(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [15:0] imm);
        return {op, 5'd1, rt, imm};
    endfunction

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] stepLfsr(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic addRow(input logic [31:0] ins, input logic [31:0] rs,
                          input logic [31:0] rt, input logic [31:0] data,
                          input logic [4:0] dest, input logic [2:0] flags);
        rows.push_back({ins, rs, rt, data, dest, flags});
    endtask

    task automatic buildTable();
        // R-type ALU, writes rd
        addRow(rInst(mipsPkg::functAdd, 5'd3, 5'd0), 32'h7FFFFFFF, 32'h1,
               32'h80000000, 5'd3, 3'b100);
        addRow(rInst(mipsPkg::functAddu, 5'd4, 5'd0), 32'hFFFFFFFF, 32'h2,
               32'h1, 5'd4, 3'b100);
        addRow(rInst(mipsPkg::functSub, 5'd5, 5'd0), 32'h5, 32'h7,
               32'hFFFFFFFE, 5'd5, 3'b100);
        addRow(rInst(mipsPkg::functSubu, 5'd6, 5'd0), 32'h80000000, 32'h1,
               32'h7FFFFFFF, 5'd6, 3'b100);
        addRow(rInst(mipsPkg::functAnd, 5'd7, 5'd0), 32'hF0F0F0F0, 32'hFF00FF00,
               32'hF000F000, 5'd7, 3'b100);
        addRow(rInst(mipsPkg::functOr, 5'd8, 5'd0), 32'hF0F0F0F0, 32'h0F000F00,
               32'hFFF0FFF0, 5'd8, 3'b100);
        addRow(rInst(mipsPkg::functXor, 5'd9, 5'd0), 32'hAAAA5555, 32'hFFFF0000,
               32'h55555555, 5'd9, 3'b100);
        addRow(rInst(mipsPkg::functNor, 5'd10, 5'd0), 32'h0000FFFF, 32'h00FF0000,
               32'hFF000000, 5'd10, 3'b100);
        addRow(rInst(mipsPkg::functSlt, 5'd11, 5'd0), 32'hFFFFFFFF, 32'h1,
               32'h1, 5'd11, 3'b100);
        addRow(rInst(mipsPkg::functSltu, 5'd12, 5'd0), 32'hFFFFFFFF, 32'h1,
               32'h0, 5'd12, 3'b100);
        // Shifts
        addRow(rInst(mipsPkg::functSll, 5'd13, 5'd4), 32'h12345678, 32'hF,
               32'hF0, 5'd13, 3'b100);
        addRow(rInst(mipsPkg::functSrl, 5'd14, 5'd8), 32'h0, 32'h80000000,
               32'h00800000, 5'd14, 3'b100);
        addRow(rInst(mipsPkg::functSra, 5'd15, 5'd8), 32'h0, 32'h80000000,
               32'hFF800000, 5'd15, 3'b100);
        addRow(rInst(mipsPkg::functSllv, 5'd16, 5'd0), 32'h24, 32'h1,
               32'h10, 5'd16, 3'b100);
        addRow(rInst(mipsPkg::functSrlv, 5'd17, 5'd0), 32'h1F, 32'hF0000000,
               32'h1, 5'd17, 3'b100);
        addRow(rInst(mipsPkg::functSrav, 5'd18, 5'd0), 32'h44, 32'h80000010,
               32'hF8000001, 5'd18, 3'b100);
        // Immediates, writes rt
        addRow(iInst(mipsPkg::opAddi, 5'd21, 16'hFFFF), 32'h10, 32'h0,
               32'hF, 5'd21, 3'b100);
        addRow(iInst(mipsPkg::opAddiu, 5'd22, 16'h8000), 32'h10000, 32'h0,
               32'h8000, 5'd22, 3'b100);
        addRow(iInst(mipsPkg::opSlti, 5'd23, 16'hFFFE), 32'hFFFFFFFD, 32'h0,
               32'h1, 5'd23, 3'b100);
        addRow(iInst(mipsPkg::opSltiu, 5'd24, 16'hFFFF), 32'h1234, 32'h0,
               32'h1, 5'd24, 3'b100);
        addRow(iInst(mipsPkg::opAndi, 5'd25, 16'hF0F0), 32'hFFFFFFFF, 32'h0,
               32'hF0F0, 5'd25, 3'b100);
        addRow(iInst(mipsPkg::opOri, 5'd26, 16'h8001), 32'h12340000, 32'h0,
               32'h12348001, 5'd26, 3'b100);
        addRow(iInst(mipsPkg::opXori, 5'd27, 16'hFFFF), 32'hFFFF0F0F, 32'h0,
               32'hFFFFF0F0, 5'd27, 3'b100);
        addRow(iInst(mipsPkg::opLui, 5'd28, 16'hBEEF), 32'h0, 32'h0,
               32'hBEEF0000, 5'd28, 3'b100);
        // Branches, both outcomes of each
        addRow(iInst(mipsPkg::opBeq, 5'd2, 16'h10), 32'h55, 32'h55,
               32'h0, 5'd0, 3'b010);
        addRow(iInst(mipsPkg::opBeq, 5'd2, 16'h10), 32'h55, 32'h56,
               32'h0, 5'd0, 3'b000);
        addRow(iInst(mipsPkg::opBne, 5'd2, 16'h10), 32'h1, 32'h2,
               32'h0, 5'd0, 3'b010);
        addRow(iInst(mipsPkg::opBne, 5'd2, 16'h10), 32'h7, 32'h7,
               32'h0, 5'd0, 3'b000);
        addRow(iInst(mipsPkg::opBlez, 5'd0, 16'h10), 32'h0, 32'h0,
               32'h0, 5'd0, 3'b010);
        addRow(iInst(mipsPkg::opBlez, 5'd0, 16'h10), 32'h80000000, 32'h0,
               32'h0, 5'd0, 3'b010);
        addRow(iInst(mipsPkg::opBlez, 5'd0, 16'h10), 32'h1, 32'h0,
               32'h0, 5'd0, 3'b000);
        addRow(iInst(mipsPkg::opBgtz, 5'd0, 16'h10), 32'h80000000, 32'h0,
               32'h0, 5'd0, 3'b000);
        addRow(iInst(mipsPkg::opBgtz, 5'd0, 16'h10), 32'h1, 32'h0,
               32'h0, 5'd0, 3'b010);
        addRow(iInst(mipsPkg::opRegimm, mipsPkg::rtBltz, 16'h10), 32'hFFFFFFFF, 32'h0,
               32'h0, 5'd0, 3'b010);
        addRow(iInst(mipsPkg::opRegimm, mipsPkg::rtBltz, 16'h10), 32'h0, 32'h0,
               32'h0, 5'd0, 3'b000);
        addRow(iInst(mipsPkg::opRegimm, mipsPkg::rtBgez, 16'h10), 32'h80000000, 32'h0,
               32'h0, 5'd0, 3'b000);
        addRow(iInst(mipsPkg::opRegimm, mipsPkg::rtBgez, 16'h10), 32'h0, 32'h0,
               32'h0, 5'd0, 3'b010);
        // Load, mult, jump, unknown opcode
        addRow(iInst(6'b100011, 5'd8, 16'h4), 32'h100, 32'h0,
               32'h0, 5'd0, 3'b001);
        addRow(rInst(6'b011000, 5'd0, 5'd0), 32'h3, 32'h4,
               32'h0, 5'd0, 3'b001);
        addRow(iInst(6'b000010, 5'd0, 16'h100), 32'h0, 32'h0,
               32'h0, 5'd0, 3'b001);
        addRow(iInst(6'b111111, 5'd9, 16'h1), 32'h7, 32'h8,
               32'h0, 5'd0, 3'b001);
        // r0 destination, computed but not written
        addRow(rInst(mipsPkg::functAdd, 5'd0, 5'd0), 32'h1, 32'h2,
               32'h3, 5'd0, 3'b000);
        addRow(iInst(mipsPkg::opOri, 5'd0, 16'h5), 32'h0, 32'h0,
               32'h5, 5'd0, 3'b000);
    endtask

    task automatic driveRow(input int idx);
        if (idx < rows.size()) begin
            inValid = 1'b1;
            instr   = rows[idx].instr;
            rsValue = rows[idx].rsVal;
            rtValue = rows[idx].rtVal;
        end else begin
            inValid = 1'b0;
            instr   = '0;
            rsValue = '0;
            rtValue = '0;
        end
    endtask

    //////////////////////////////
    // Checking
    //////////////////////////////
    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h (result %0d)",
                     $time, what, got, expected, matched);
            $display("Result: FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic checkOutput();
        testRow exp;
        if (expQ.size() == 0) begin
            $display("At %0t ns the unit delivered a result that was never sent in", $time);
            $display("Result: FAILED");
            $fatal(1, "Extra output");
        end else begin
            exp = expQ.pop_front();
            checkValue("outData", outData, exp.data);
            checkValue("outDest", {27'd0, outDest}, {27'd0, exp.dest});
            checkValue("outWriteEn", {31'd0, outWriteEn}, {31'd0, exp.flags[2]});
            checkValue("outBranchTaken", {31'd0, outBranchTaken}, {31'd0, exp.flags[1]});
            checkValue("outIllegal", {31'd0, outIllegal}, {31'd0, exp.flags[0]});
            matched++;
        end
    endtask

    task automatic watchdog();
        int limit;
        limit = resetCycles + rows.size() * cyclesPerRow;
        #(limit * clkPeriod);
        $display("The unit hung: only %0d of %0d results came out within %0d cycles",
                 matched, rows.size(), limit);
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    endtask

    initial begin
        int   sent;
        logic inFire;
        logic outFire;
        rstN     = 1'b0;
        inValid  = 1'b0;
        instr    = '0;
        rsValue  = '0;
        rtValue  = '0;
        outReady = 1'b0;
        sent     = 0;
        matched  = 0;
        lfsr     = 8'd49;
        buildTable();
        fork
            watchdog();
        join_none

        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
        driveRow(0);
        lfsr     = stepLfsr(lfsr);
        outReady = lfsr[0];

        // Handshakes are sampled mid-cycle, once inputs have settled
        while (matched < rows.size()) begin
            @(negedge clk);
            inFire  = inValid && inReady;
            outFire = outValid && outReady;
            if (inFire) begin
                expQ.push_back(rows[sent]);
            end
            if (outFire) begin
                checkOutput();
            end
            @(posedge clk);
            #1;
            if (inFire) begin
                sent++;
            end
            driveRow(sent);
            lfsr     = stepLfsr(lfsr);
            outReady = lfsr[0];
        end

        // A duplicated last result would still show up here
        outReady = 1'b1;
        repeat (drainCycles) begin
            @(negedge clk);
            if (outValid) begin
                checkOutput();
            end
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* build.f */
hw/mipsPkg.sv
hw/stageIf.sv
hw/instrDecode.sv
hw/aluExecute.sv
hw/resultStage.sv
hw/mipsExecUnit.sv
tb/mipsExecUnit_properties.sv
tb/mipsExecUnit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, then look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module mipsExecUnit_tb -f build.f -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }
